// ==== axi_pkg.sv ====
package axi_pkg;

	localparam int axi_id_w = 4;
	localparam int axi_addr_w = 64;
	localparam int axi_data_w = 32;
	localparam int axi_strb_w = 4;
	localparam int axi_len_w = 8;

	localparam int axi_size_w = 3; // AWSIZE field
	localparam int axi_burst_w = 2;
	localparam int axi_cache_w = 4;
	localparam int axi_resp_w = 2;

	typedef enum logic [axi_burst_w-1:0] {
		burst_fixed = 2'b00,
		burst_incr = 2'b01,
		burst_wrap = 2'b10
	} axi_burst_e;

	typedef enum logic [axi_resp_w-1:0] {
		resp_okay = 2'b00,
		resp_exokay = 2'b01,
		resp_slverr = 2'b10,
		resp_decerr = 2'b11
	} axi_resp_e;

endpackage

// ==== fifo_async.sv ====
`timescale 1ns/1ns

module fifo_async #(
	parameter int dsize = 8,
	parameter int asize = 4
) (
	input logic wr_rst,
	input logic wr_clk,
	input logic [dsize-1:0] din,
	input logic wr_en,
	output logic full,

	input logic rd_rst,
	input logic rd_clk,
	input logic rd_en,
	output logic [dsize-1:0] dout,
	output logic empty
);

	logic [dsize-1:0] mem [0:(1 << asize)-1];

	logic [asize:0] wbin;
	logic [asize:0] wgray;
	logic [asize:0] wbin_next;
	logic [asize:0] wgray_next;
	logic [asize:0] wq1_rgray;
	logic [asize:0] wq2_rgray;
	logic wr_fire;

	logic [asize:0] rbin;
	logic [asize:0] rgray;
	logic [asize:0] rbin_next;
	logic [asize:0] rgray_next;
	logic [asize:0] rq1_wgray;
	logic [asize:0] rq2_wgray;
	logic rd_fire;

	assign wr_fire = wr_en && !full;
	assign wbin_next = wr_fire ? wbin + 1'b1 : wbin;
	assign wgray_next = (wbin_next >> 1) ^ wbin_next;

	always_ff @(posedge wr_clk) begin
		if (wr_fire)
			mem[wbin[asize-1:0]] <= din;
	end

	always_ff @(posedge wr_clk or posedge wr_rst) begin
		if (wr_rst) begin
			wbin <= '0;
			wgray <= '0;
			wq1_rgray <= '0;
			wq2_rgray <= '0;
			full <= 1'b0;
		end else begin
			wbin <= wbin_next;
			wgray <= wgray_next;
			wq1_rgray <= rgray;
			wq2_rgray <= wq1_rgray;
			// Full when the pointers differ only in the two top Gray bits
			full <= wgray_next == {~wq2_rgray[asize:asize-1], wq2_rgray[asize-2:0]};
		end
	end

	assign rd_fire = rd_en && !empty;
	assign rbin_next = rd_fire ? rbin + 1'b1 : rbin;
	assign rgray_next = (rbin_next >> 1) ^ rbin_next;

	assign dout = mem[rbin[asize-1:0]]; // Head word shows without a read

	always_ff @(posedge rd_clk or posedge rd_rst) begin
		if (rd_rst) begin
			rbin <= '0;
			rgray <= '0;
			rq1_wgray <= '0;
			rq2_wgray <= '0;
			empty <= 1'b1;
		end else begin
			rbin <= rbin_next;
			rgray <= rgray_next;
			rq1_wgray <= wgray;
			rq2_wgray <= rq1_wgray;
			empty <= rgray_next == rq2_wgray;
		end
	end

endmodule

// ==== files.f ====
axi_pkg.sv
pci_pkg.sv
wpath_if.sv
fifo_async.sv
pci_master_wpath.sv
pci_wr_engine.sv
pci_master_wr_top.sv
tb_clkgen.sv
tb_checker.sv
tb_top.sv

// ==== pci_master_wpath.sv ====
`timescale 1ns/1ns

module pci_master_wpath import axi_pkg::*, pci_pkg::*; (
	input logic mst_s_aclk,
	input logic mst_s_aresetn,

	input logic [axi_id_w-1:0] awid,
	input logic [axi_addr_w-1:0] awaddr,
	input logic [axi_len_w-1:0] awlen,
	input logic [axi_size_w-1:0] awsize,
	input logic [axi_burst_w-1:0] awburst,
	input logic [axi_cache_w-1:0] awcache,
	input logic awvalid,
	output logic awready,

	input logic [axi_id_w-1:0] wid,
	input logic [axi_data_w-1:0] wdata,
	input logic [axi_strb_w-1:0] wstrb,
	input logic wlast,
	input logic wvalid,
	output logic wready,

	output logic [axi_id_w-1:0] bid,
	output logic [axi_resp_w-1:0] bresp,
	output logic bvalid,
	input logic bready,

	input logic clk,
	input logic rst,

	input logic [buf_idx_w-1:0] data_idx,
	output logic [axi_data_w-1:0] data_dout,
	output logic [axi_strb_w-1:0] data_strb,

	wpath_cmd_if.source cmd,
	wpath_resp_if.sink resp
);

	// Burst length is counted from the W beats, so awlen, awsize, awburst,
	// awcache and wid take no part in the write path

	logic [axi_strb_w+axi_data_w-1:0] buf_mem [0:buf_depth-1];
	logic [buf_idx_w-1:0] widx;
	logic [buf_idx_w-1:0] ridx;
	logic [axi_len_w-1:0] beat_cnt;
	logic buf_full;

	logic w_fire;
	logic aw_fire;
	logic len_full;
	logic len_empty;
	logic addr_full;
	logic addr_empty;
	logic [axi_id_w+axi_addr_w-1:0] addr_dout;
	logic cmd_fire;

	logic resp_full;
	logic resp_push;
	logic b_empty;
	logic b_fire;
	logic [axi_len_w-1:0] b_len;

	assign awready = !addr_full;
	assign wready = !buf_full && !len_full;
	assign w_fire = wvalid && wready;
	assign aw_fire = awvalid && awready;

	assign buf_full = (widx + 1'b1) == ridx; // One slot stays free

	always_ff @(posedge mst_s_aclk) begin
		if (w_fire)
			buf_mem[widx] <= {wstrb, wdata};
	end

	assign {data_strb, data_dout} = buf_mem[data_idx];

	always_ff @(posedge mst_s_aclk or negedge mst_s_aresetn) begin
		if (!mst_s_aresetn) begin
			widx <= '0;
			beat_cnt <= '0;
		end else if (w_fire) begin
			widx <= widx + 1'b1;
			beat_cnt <= wlast ? '0 : beat_cnt + 1'b1; // Ends as beats minus one
		end
	end

	fifo_async #(.dsize(axi_len_w), .asize(len_fifo_asize)) len_fifo_i (
		.wr_rst(!mst_s_aresetn),
		.wr_clk(mst_s_aclk),
		.din(beat_cnt),
		.wr_en(w_fire && wlast),
		.full(len_full),
		.rd_rst(rst),
		.rd_clk(clk),
		.rd_en(cmd_fire),
		.dout(cmd.len),
		.empty(len_empty)
	);

	fifo_async #(.dsize(axi_id_w+axi_addr_w), .asize(len_fifo_asize)) addr_fifo_i (
		.wr_rst(!mst_s_aresetn),
		.wr_clk(mst_s_aclk),
		.din({awid, awaddr}),
		.wr_en(aw_fire),
		.full(addr_full),
		.rd_rst(rst),
		.rd_clk(clk),
		.rd_en(cmd_fire),
		.dout(addr_dout),
		.empty(addr_empty)
	);

	assign {cmd.id, cmd.addr} = addr_dout;
	assign cmd.valid = !addr_empty && !len_empty; // A burst needs both halves
	assign cmd_fire = cmd.valid && cmd.ready;

	assign resp.ready = !resp_full;
	assign resp_push = resp.valid && resp.ready;

	fifo_async #(.dsize(axi_id_w+axi_len_w), .asize(resp_fifo_asize)) resp_fifo_i (
		.wr_rst(rst),
		.wr_clk(clk),
		.din({resp.id, resp.len}),
		.wr_en(resp_push),
		.full(resp_full),
		.rd_rst(!mst_s_aresetn),
		.rd_clk(mst_s_aclk),
		.rd_en(b_fire),
		.dout({bid, b_len}),
		.empty(b_empty)
	);

	assign bvalid = !b_empty;
	assign bresp = resp_okay;
	assign b_fire = bvalid && bready;

	// Buffer space of a burst is freed once its B is taken
	always_ff @(posedge mst_s_aclk or negedge mst_s_aresetn) begin
		if (!mst_s_aresetn)
			ridx <= '0;
		else if (b_fire)
			ridx <= ridx + buf_idx_w'(b_len) + 1'b1;
	end

endmodule

// ==== pci_master_wr_top.sv ====
`timescale 1ns/1ns

module pci_master_wr_top import axi_pkg::*, pci_pkg::*; (
	input logic mst_s_aclk,
	input logic mst_s_aresetn,

	input logic [axi_id_w-1:0] awid,
	input logic [axi_addr_w-1:0] awaddr,
	input logic [axi_len_w-1:0] awlen,
	input logic [axi_size_w-1:0] awsize,
	input logic [axi_burst_w-1:0] awburst,
	input logic [axi_cache_w-1:0] awcache,
	input logic awvalid,
	output logic awready,

	input logic [axi_id_w-1:0] wid,
	input logic [axi_data_w-1:0] wdata,
	input logic [axi_strb_w-1:0] wstrb,
	input logic wlast,
	input logic wvalid,
	output logic wready,

	output logic [axi_id_w-1:0] bid,
	output logic [axi_resp_w-1:0] bresp,
	output logic bvalid,
	input logic bready,

	input logic clk,
	input logic rst,

	output logic [axi_addr_w-1:0] tgt_addr,
	output logic [axi_data_w-1:0] tgt_data,
	output logic [axi_strb_w-1:0] tgt_strb,
	output logic tgt_valid,
	input logic tgt_ready
);

	wpath_cmd_if cmd_if ();
	wpath_resp_if resp_if ();

	logic [buf_idx_w-1:0] data_idx;
	logic [axi_data_w-1:0] data_dout;
	logic [axi_strb_w-1:0] data_strb;

	pci_master_wpath pci_master_wpath_i (
		.mst_s_aclk(mst_s_aclk),
		.mst_s_aresetn(mst_s_aresetn),
		.awid(awid),
		.awaddr(awaddr),
		.awlen(awlen),
		.awsize(awsize),
		.awburst(awburst),
		.awcache(awcache),
		.awvalid(awvalid),
		.awready(awready),
		.wid(wid),
		.wdata(wdata),
		.wstrb(wstrb),
		.wlast(wlast),
		.wvalid(wvalid),
		.wready(wready),
		.bid(bid),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.clk(clk),
		.rst(rst),
		.data_idx(data_idx),
		.data_dout(data_dout),
		.data_strb(data_strb),
		.cmd(cmd_if),
		.resp(resp_if)
	);

	pci_wr_engine pci_wr_engine_i (
		.clk(clk),
		.rst(rst),
		.cmd(cmd_if),
		.resp(resp_if),
		.data_idx(data_idx),
		.data_dout(data_dout),
		.data_strb(data_strb),
		.tgt_addr(tgt_addr),
		.tgt_data(tgt_data),
		.tgt_strb(tgt_strb),
		.tgt_valid(tgt_valid),
		.tgt_ready(tgt_ready)
	);

endmodule

// ==== pci_pkg.sv ====
package pci_pkg;

	localparam int buf_depth = 1024; // W beats held until B retires them
	localparam int buf_idx_w = 10;

	// Log2 depths of the clock crossing FIFOs
	localparam int len_fifo_asize = 8;
	localparam int resp_fifo_asize = 4;

	localparam int beat_bytes = 4; // Address step between target beats

	typedef enum logic [1:0] {
		eng_idle = 2'b00,
		eng_write = 2'b01,
		eng_resp = 2'b10
	} eng_state_e;

endpackage

// ==== pci_wr_engine.sv ====
`timescale 1ns/1ns

module pci_wr_engine import axi_pkg::*, pci_pkg::*; (
	input logic clk,
	input logic rst,

	wpath_cmd_if.sink cmd,
	wpath_resp_if.source resp,

	output logic [buf_idx_w-1:0] data_idx,
	input logic [axi_data_w-1:0] data_dout,
	input logic [axi_strb_w-1:0] data_strb,

	output logic [axi_addr_w-1:0] tgt_addr,
	output logic [axi_data_w-1:0] tgt_data,
	output logic [axi_strb_w-1:0] tgt_strb,
	output logic tgt_valid,
	input logic tgt_ready
);

	eng_state_e state;
	logic [buf_idx_w-1:0] base; // Buffer entry of the current burst's first beat
	logic [axi_len_w-1:0] beat;
	logic [axi_addr_w-1:0] addr_q;
	logic [axi_id_w-1:0] id_q;
	logic [axi_len_w-1:0] len_q;
	logic tgt_fire;

	assign cmd.ready = state == eng_idle;
	assign tgt_valid = state == eng_write;
	assign tgt_fire = tgt_valid && tgt_ready;

	assign data_idx = base + buf_idx_w'(beat); // Wraps with the buffer
	assign tgt_addr = addr_q;
	assign tgt_data = data_dout;
	assign tgt_strb = data_strb;

	assign resp.valid = state == eng_resp;
	assign resp.id = id_q;
	assign resp.len = len_q;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= eng_idle;
			base <= '0;
			beat <= '0;
		end else begin
			case (state)
				eng_idle: if (cmd.valid) begin
					beat <= '0;
					state <= eng_write;
				end
				eng_write: if (tgt_fire) begin
					if (beat == len_q)
						state <= eng_resp;
					else
						beat <= beat + 1'b1;
				end
				eng_resp: if (resp.ready) begin
					base <= base + buf_idx_w'(len_q) + 1'b1;
					state <= eng_idle;
				end
				default: state <= eng_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (cmd.valid && cmd.ready) begin
			id_q <= cmd.id;
			len_q <= cmd.len;
			addr_q <= cmd.addr;
		end else if (tgt_fire) begin
			addr_q <= addr_q + axi_addr_w'(beat_bytes);
		end
	end

endmodule

// ==== tb_checker.sv ====
`timescale 1ns/1ns

module tb_checker import axi_pkg::*; (
	input logic mst_s_aclk,
	input logic mst_s_aresetn,
	input logic clk,
	input logic rst,
	input logic awready,
	input logic wready,
	input logic [axi_id_w-1:0] bid,
	input logic [axi_resp_w-1:0] bresp,
	input logic bvalid,
	input logic bready,
	input logic [axi_addr_w-1:0] tgt_addr,
	input logic [axi_data_w-1:0] tgt_data,
	input logic [axi_strb_w-1:0] tgt_strb,
	input logic tgt_valid,
	input logic tgt_ready,
	output int beats_seen,
	output int resps_seen,
	output int tgt_errs,
	output int b_errs,
	output int misc_errs
);

	logic [axi_addr_w+axi_data_w+axi_strb_w-1:0] beat_q [$]; // {addr, data, strb} in order
	logic [axi_id_w-1:0] id_q [$];
	int end_q [$]; // Target beats that must be done before this burst's B

	logic [axi_addr_w+axi_data_w+axi_strb_w-1:0] held_beat;
	logic [axi_id_w-1:0] held_bid;
	logic tgt_stalled;
	logic b_stalled;

	task automatic push_beat(input logic [axi_addr_w-1:0] addr,
		input logic [axi_data_w-1:0] data, input logic [axi_strb_w-1:0] strb);
		beat_q.push_back({addr, data, strb});
	endtask

	task automatic push_resp(input logic [axi_id_w-1:0] id, input int beats_done);
		id_q.push_back(id);
		end_q.push_back(beats_done);
	endtask

	task automatic expect_flag(input string name, input logic exp, input logic got);
		if (got !== exp) begin
			$display("ERR %s: expected %h, got %h", name, exp, got);
			misc_errs++;
		end
	endtask

	task automatic check_reset_state();
		expect_flag("awready", 1'b1, awready);
		expect_flag("wready", 1'b1, wready);
		expect_flag("bvalid", 1'b0, bvalid);
		expect_flag("tgt_valid", 1'b0, tgt_valid);
	endtask

	task automatic check_drained();
		if (beat_q.size() != 0) begin
			$display("%0d expected target beats never appeared", beat_q.size());
			misc_errs++;
		end
		if (id_q.size() != 0) begin
			$display("%0d expected B responses never appeared", id_q.size());
			misc_errs++;
		end
	endtask

	task automatic compare_beat();
		logic [axi_addr_w-1:0] e_addr;
		logic [axi_data_w-1:0] e_data;
		logic [axi_strb_w-1:0] e_strb;
		if (beat_q.size() == 0) begin
			$display("Target write to address %h arrived with no beat expected", tgt_addr);
			tgt_errs++;
		end else begin
			{e_addr, e_data, e_strb} = beat_q.pop_front();
			if (tgt_addr !== e_addr) begin
				$display("ERR tgt_addr beat %0d: expected %h, got %h", beats_seen, e_addr, tgt_addr);
				tgt_errs++;
			end
			if (tgt_data !== e_data) begin
				$display("ERR tgt_data beat %0d: expected %h, got %h", beats_seen, e_data, tgt_data);
				tgt_errs++;
			end
			if (tgt_strb !== e_strb) begin
				$display("ERR tgt_strb beat %0d: expected %h, got %h", beats_seen, e_strb, tgt_strb);
				tgt_errs++;
			end
		end
		beats_seen++;
	endtask

	task automatic compare_resp();
		logic [axi_id_w-1:0] e_id;
		int e_end;
		if (id_q.size() == 0) begin
			$display("B response with bid %h arrived with no burst outstanding", bid);
			b_errs++;
		end else begin
			e_id = id_q.pop_front();
			e_end = end_q.pop_front();
			if (bid !== e_id) begin
				$display("ERR bid: expected %h, got %h", e_id, bid);
				b_errs++;
			end
			if (bresp !== resp_okay) begin
				$display("ERR bresp: expected %h, got %h", resp_okay, bresp);
				b_errs++;
			end
			if (beats_seen < e_end) begin
				$display("ERR target beat count at B: expected %h, got %h", e_end, beats_seen);
				b_errs++;
			end
		end
		resps_seen++;
	endtask

	always @(posedge clk) begin
		if (rst) begin
			tgt_stalled = 1'b0;
		end else begin
			if (tgt_stalled && !tgt_valid) begin
				$display("tgt_valid dropped at %0t before tgt_ready was high", $time);
				tgt_errs++;
			end else if (tgt_stalled && {tgt_addr, tgt_data, tgt_strb} !== held_beat) begin
				$display("ERR {tgt_addr,tgt_data,tgt_strb} held: expected %h, got %h",
					held_beat, {tgt_addr, tgt_data, tgt_strb});
				tgt_errs++;
			end
			if (tgt_valid && tgt_ready)
				compare_beat();
			tgt_stalled = tgt_valid && !tgt_ready;
			held_beat = {tgt_addr, tgt_data, tgt_strb};
		end
	end

	always @(posedge mst_s_aclk) begin
		if (!mst_s_aresetn) begin
			b_stalled = 1'b0;
		end else begin
			if (b_stalled && !bvalid) begin
				$display("bvalid dropped at %0t before bready was high", $time);
				b_errs++;
			end else if (b_stalled && bid !== held_bid) begin
				$display("ERR bid held: expected %h, got %h", held_bid, bid);
				b_errs++;
			end
			if (bvalid && bready)
				compare_resp();
			b_stalled = bvalid && !bready;
			held_bid = bid;
		end
	end

endmodule

// ==== tb_clkgen.sv ====
`timescale 1ns/1ns

module tb_clkgen (
	output logic mst_s_aclk,
	output logic mst_s_aresetn,
	output logic clk,
	output logic rst
);

	initial begin
		mst_s_aclk = 1'b0;
		forever #5 mst_s_aclk = !mst_s_aclk; // AXI side, 10 ns period
	end

	initial begin
		clk = 1'b0;
		forever #7 clk = !clk; // PCI side, 14 ns period
	end

	// Both resets let go on a falling edge, clear of the flops' active edge
	initial begin
		mst_s_aresetn = 1'b0;
		repeat (3) @(posedge mst_s_aclk);
		@(negedge mst_s_aclk);
		mst_s_aresetn = 1'b1;
	end

	initial begin
		rst = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

// ==== tb_top.sv ====
`timescale 1ns/1ns

module tb_top import axi_pkg::*; ();

	localparam int n_bursts = 12;
	localparam int wait_limit = 20000; // aclk cycles allowed for any one wait
	localparam logic [31:0] rng_seed = 32'h1d77d896;

	logic mst_s_aclk;
	logic mst_s_aresetn;
	logic clk;
	logic rst;

	logic [axi_id_w-1:0] awid;
	logic [axi_addr_w-1:0] awaddr;
	logic [axi_len_w-1:0] awlen;
	logic [axi_size_w-1:0] awsize;
	logic [axi_burst_w-1:0] awburst;
	logic [axi_cache_w-1:0] awcache;
	logic awvalid;
	logic awready;
	logic [axi_id_w-1:0] wid;
	logic [axi_data_w-1:0] wdata;
	logic [axi_strb_w-1:0] wstrb;
	logic wlast;
	logic wvalid;
	logic wready;
	logic [axi_id_w-1:0] bid;
	logic [axi_resp_w-1:0] bresp;
	logic bvalid;
	logic bready;
	logic [axi_addr_w-1:0] tgt_addr;
	logic [axi_data_w-1:0] tgt_data;
	logic [axi_strb_w-1:0] tgt_strb;
	logic tgt_valid;
	logic tgt_ready;

	logic [axi_id_w-1:0] row_id [n_bursts];
	logic [axi_addr_w-1:0] row_addr [n_bursts];
	logic [axi_len_w-1:0] row_awlen [n_bursts];
	int row_beats [n_bursts];
	logic [axi_strb_w-1:0] row_strb [n_bursts];
	logic row_aw_first [n_bursts];

	logic [axi_data_w-1:0] burst_data [256];
	logic [axi_strb_w-1:0] burst_strb [256];
	logic [31:0] data_rng;
	int beats_queued;
	int timeouts;

	int beats_seen;
	int resps_seen;
	int tgt_errs;
	int b_errs;
	int misc_errs;

	tb_clkgen clkgen_inst (
		.mst_s_aclk(mst_s_aclk),
		.mst_s_aresetn(mst_s_aresetn),
		.clk(clk),
		.rst(rst)
	);

	pci_master_wr_top pci_master_wr_top_inst (
		.mst_s_aclk(mst_s_aclk), .mst_s_aresetn(mst_s_aresetn),
		.awid(awid), .awaddr(awaddr), .awlen(awlen), .awsize(awsize),
		.awburst(awburst), .awcache(awcache), .awvalid(awvalid), .awready(awready),
		.wid(wid), .wdata(wdata), .wstrb(wstrb), .wlast(wlast),
		.wvalid(wvalid), .wready(wready),
		.bid(bid), .bresp(bresp), .bvalid(bvalid), .bready(bready),
		.clk(clk), .rst(rst),
		.tgt_addr(tgt_addr), .tgt_data(tgt_data), .tgt_strb(tgt_strb),
		.tgt_valid(tgt_valid), .tgt_ready(tgt_ready)
	);

	tb_checker tb_checker_inst (
		.mst_s_aclk(mst_s_aclk), .mst_s_aresetn(mst_s_aresetn), .clk(clk), .rst(rst),
		.awready(awready), .wready(wready),
		.bid(bid), .bresp(bresp), .bvalid(bvalid), .bready(bready),
		.tgt_addr(tgt_addr), .tgt_data(tgt_data), .tgt_strb(tgt_strb),
		.tgt_valid(tgt_valid), .tgt_ready(tgt_ready),
		.beats_seen(beats_seen), .resps_seen(resps_seen),
		.tgt_errs(tgt_errs), .b_errs(b_errs), .misc_errs(misc_errs)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	task automatic set_row(input int r, input logic [axi_id_w-1:0] id,
		input logic [axi_addr_w-1:0] addr, input logic [axi_len_w-1:0] len,
		input int beats, input logic [axi_strb_w-1:0] strb, input logic aw_first);
		row_id[r] = id;
		row_addr[r] = addr;
		row_awlen[r] = len;
		row_beats[r] = beats;
		row_strb[r] = strb;
		row_aw_first[r] = aw_first;
	endtask

	// Rows 3, 7 and 10 carry an awlen that disagrees with the W beat count
	task automatic load_table();
		//      row  awid   awaddr                 awlen   beats strobe AW first
		set_row(0, 4'h1, 64'h0000_0000_1000_0000, 8'd199, 200, 4'hf, 1'b1);
		set_row(1, 4'h2, 64'h0000_0001_2000_0000, 8'd149, 150, 4'h3, 1'b0);
		set_row(2, 4'h3, 64'h0000_0000_3000_0400, 8'd255, 256, 4'hf, 1'b1);
		set_row(3, 4'h4, 64'h0000_00ff_4000_0000, 8'd7, 100, 4'h5, 1'b1);
		set_row(4, 4'h5, 64'h0000_0000_5000_0100, 8'd179, 180, 4'he, 1'b0);
		set_row(5, 4'h6, 64'h8000_0000_6000_0000, 8'd63, 64, 4'hf, 1'b1);
		set_row(6, 4'h7, 64'h0000_0000_7000_0000, 8'd0, 1, 4'h1, 1'b0);
		set_row(7, 4'h8, 64'h0000_0000_8000_0000, 8'd255, 120, 4'hc, 1'b1);
		set_row(8, 4'h9, 64'h0000_0000_9000_0000, 8'd29, 30, 4'hf, 1'b0);
		set_row(9, 4'ha, 64'h0000_0000_a000_0000, 8'd89, 90, 4'h9, 1'b1);
		set_row(10, 4'hb, 64'h0000_0000_b000_0000, 8'd3, 16, 4'hf, 1'b0);
		set_row(11, 4'hc, 64'h0000_0000_c000_0000, 8'd39, 40, 4'h6, 1'b1);
	endtask

	task automatic make_burst(input int r);
		int i;
		logic [7:0] rot;
		for (i = 0; i < row_beats[r]; i++) begin
			data_rng = xorshift32(data_rng);
			burst_data[i] = data_rng;
			rot = {row_strb[r], row_strb[r]} >> (4 - i % 4); // Strobe rotates per beat
			burst_strb[i] = rot[3:0];
			tb_checker_inst.push_beat(row_addr[r] + axi_addr_w'(4 * i), burst_data[i],
				burst_strb[i]);
		end
		beats_queued += row_beats[r];
		tb_checker_inst.push_resp(row_id[r], beats_queued);
	endtask

	task automatic wait_ready(input logic is_w, input string what);
		int n;
		n = 0;
		while (!(is_w ? wready : awready) && n < wait_limit) begin
			@(negedge mst_s_aclk);
			n++;
		end
		if (!(is_w ? wready : awready)) begin
			$display("Timeout: %s stayed low too long", what);
			timeouts++;
		end
	endtask

	task automatic send_aw(input int r);
		awid = row_id[r];
		awaddr = row_addr[r];
		awlen = row_awlen[r];
		awvalid = 1'b1;
		wait_ready(1'b0, "awready");
		@(negedge mst_s_aclk);
		awvalid = 1'b0;
	endtask

	task automatic send_w(input int r);
		int i;
		for (i = 0; i < row_beats[r] && timeouts == 0; i++) begin
			wid = row_id[r];
			wdata = burst_data[i];
			wstrb = burst_strb[i];
			wlast = i == row_beats[r] - 1;
			wvalid = 1'b1;
			wait_ready(1'b1, "wready");
			@(negedge mst_s_aclk);
		end
		wvalid = 1'b0;
		wlast = 1'b0;
	endtask

	initial begin : tgt_ready_drive
		logic [31:0] r;
		tgt_ready = 1'b0;
		r = {rng_seed[15:0], rng_seed[31:16]};
		forever begin
			@(negedge clk);
			r = xorshift32(r);
			tgt_ready = r[1:0] != 2'b00;
		end
	end

	initial begin : bready_drive
		logic [31:0] r;
		bready = 1'b0;
		r = ~rng_seed;
		forever begin
			@(negedge mst_s_aclk);
			r = xorshift32(r);
			bready = r[1:0] != 2'b00;
		end
	end

	initial begin : stimulus
		int row;
		int n;
		awid = '0;
		awaddr = '0;
		awlen = '0;
		awsize = 3'd2; // Full 32-bit beats
		awburst = burst_incr;
		awcache = '0;
		awvalid = 1'b0;
		wid = '0;
		wdata = '0;
		wstrb = '0;
		wlast = 1'b0;
		wvalid = 1'b0;
		data_rng = rng_seed;
		beats_queued = 0;
		load_table();
		n = 0;
		while ((mst_s_aresetn !== 1'b1 || rst !== 1'b0) && n < 100) begin
			@(negedge mst_s_aclk);
			n++;
		end
		if (mst_s_aresetn !== 1'b1 || rst !== 1'b0) begin
			$display("Timeout: resets never released");
			timeouts++;
		end
		@(negedge mst_s_aclk);
		tb_checker_inst.check_reset_state();
		for (row = 0; row < n_bursts && timeouts == 0; row++) begin
			make_burst(row);
			if (row_aw_first[row]) begin
				send_aw(row);
				send_w(row);
			end else begin
				send_w(row);
				send_aw(row);
			end
		end
		n = 0;
		while (resps_seen < n_bursts && n < wait_limit && timeouts == 0) begin
			@(negedge mst_s_aclk);
			n++;
		end
		if (resps_seen < n_bursts && timeouts == 0) begin
			$display("Timeout: only %0d of %0d B responses arrived", resps_seen, n_bursts);
			timeouts++;
		end
		tb_checker_inst.check_drained();
		$display("Closing: %0d target beats, %0d B responses, errors target %0d B %0d other %0d, timeouts %0d",
			beats_seen, resps_seen, tgt_errs, b_errs, misc_errs, timeouts);
		if (tgt_errs + b_errs + misc_errs + timeouts == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// ==== wpath_if.sv ====
`timescale 1ns/1ns

interface wpath_cmd_if import axi_pkg::*; ();

	logic [axi_id_w-1:0] id;
	logic [axi_len_w-1:0] len; // Beats minus one
	logic [axi_addr_w-1:0] addr;
	logic valid;
	logic ready;

	modport source (
		output id,
		output len,
		output addr,
		output valid,
		input ready
	);

	modport sink (
		input id,
		input len,
		input addr,
		input valid,
		output ready
	);

endinterface

interface wpath_resp_if import axi_pkg::*; ();

	logic [axi_id_w-1:0] id;
	logic [axi_len_w-1:0] len;
	logic valid;
	logic ready;

	modport source (
		output id,
		output len,
		output valid,
		input ready
	);

	modport sink (
		input id,
		input len,
		input valid,
		output ready
	);

endinterface
